// ==== include/isp_config.svh ====
// ISP raw-to-RGB configuration
// line buffer sizing and raw sample width for the Bayer stage

`ifndef ISP_CONFIG_SVH
`define ISP_CONFIG_SVH

// ------------------------------
// line buffer
// ------------------------------
`define ISP_LINE_DEPTH 512   // words per line, two pixels each, so 1024 px
`define ISP_ADDR_W     9     // log2 of the depth

// ------------------------------
// pixel format
// ------------------------------
`define ISP_RAW_W      8     // one raw Bayer sample from the sensor

`endif

// ==== design/isp_pkg.sv ====
// ISP package
// widths and state types shared by the raw-to-RGB stage

package isp_pkg;

`include "isp_config.svh"

   // ------------------------------
   // data widths
   // ------------------------------
   typedef logic [`ISP_RAW_W-1:0]   raw_t;        // single Bayer sample
   typedef logic [2*`ISP_RAW_W-1:0] word_t;       // CSI word, even column in low byte
   typedef logic [`ISP_ADDR_W-1:0]  word_addr_t;  // word index inside one line
   typedef logic [3*`ISP_RAW_W-1:0] pix_t;        // {r, g, b}, red on top

   // ------------------------------
   // line framing
   // ------------------------------
   typedef enum logic [1:0] {
      wait_frame,     // idle until in_frame rises
      wait_line,      // in frame, between lines
      in_line,        // taking words of the current line
      wait_line_end   // line longer than the buffer, drop the rest
   } phase_state_t;

endpackage: isp_pkg

// ==== design/line_phase_tracker.sv ====
// Line phase tracker
// finds frame and line edges, counts words, keeps Bayer line parity,
// steers the line buffer and delays the current word pair by one cycle

`timescale 1ns/100ps

`include "isp_config.svh"

module line_phase_tracker (
   input  logic               clk,
   input  logic               rst,
   input  isp_pkg::word_t     word_data,
   input  logic               word_valid,
   input  logic               in_line,
   input  logic               in_frame,
   output logic               buf_wr,
   output logic               buf_rd,
   output isp_pkg::word_addr_t buf_addr,
   output isp_pkg::word_t     buf_wdata,
   output isp_pkg::word_t     cur_pair,
   output logic               quad_valid,
   output logic               quad_sof
);
   import isp_pkg::*;

   // the in_line port hides the state literal of the same name,
   // so that one is always written with its package scope
   phase_state_t state;
   logic         in_line_q, in_frame_q;   // previous levels for edge finding
   word_addr_t   word_cnt;                // next word index in the line
   word_addr_t   cur_idx;
   logic         odd_line;                // 0: R/G line, 1: G/B line
   logic         first_quad;              // no quad emitted yet this frame

   logic frame_rise, line_rise, line_fall;
   logic take_words, accept, last_word;

// ------------------------------
// edge and acceptance decode
// ------------------------------
   assign frame_rise = in_frame & ~in_frame_q;
   assign line_rise  = in_line & ~in_line_q;
   assign line_fall  = ~in_line & in_line_q;

   // first word may come on the very cycle in_line rises
   assign take_words = (state == isp_pkg::in_line) | ((state == wait_line) & line_rise);
   assign accept     = word_valid & in_line & in_frame & take_words;

   assign cur_idx   = line_rise ? '0 : word_cnt;        // rise restarts the index
   assign last_word = (cur_idx == word_addr_t'(`ISP_LINE_DEPTH - 1));

   // buffer strobes, same cycle as the accepted word
   assign buf_wr    = accept & ~odd_line;   // even line goes into memory
   assign buf_rd    = accept & odd_line;    // odd line fetches its partner
   assign buf_addr  = cur_idx;
   assign buf_wdata = word_data;

// ------------------------------
// framing FSM and counters
// ------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         state      <= wait_frame;
         in_line_q  <= 1'b0;
         in_frame_q <= 1'b0;
         word_cnt   <= '0;
         odd_line   <= 1'b0;
         first_quad <= 1'b0;
      end
      else begin
         in_line_q  <= in_line;
         in_frame_q <= in_frame;

         if (accept) word_cnt <= cur_idx + 1'b1;
         else if (line_rise) word_cnt <= '0;

         // parity flips only for lines that were actually taken
         if (frame_rise) odd_line <= 1'b0;
         else if (line_fall && (state == isp_pkg::in_line || state == wait_line_end))
            odd_line <= ~odd_line;

         if (frame_rise) first_quad <= 1'b1;
         else if (accept && odd_line) first_quad <= 1'b0;   // cleared by first quad

         case (state)
            wait_frame:    if (frame_rise) state <= wait_line;
            wait_line:     if (!in_frame) state <= wait_frame;
                           else if (line_rise) state <= (accept && last_word) ?
                                                        wait_line_end : isp_pkg::in_line;
            isp_pkg::in_line: begin
               if (!in_frame) state <= wait_frame;
               else if (line_fall) state <= wait_line;
               else if (accept && last_word) state <= wait_line_end;  // buffer full
            end
            wait_line_end: if (!in_frame) state <= wait_frame;
                           else if (line_fall) state <= wait_line;
            default:       state <= wait_frame;
         endcase
      end
   end

// ------------------------------
// current pair to the combine stage
// ------------------------------
   always_ff @(posedge clk) begin
      if (accept) cur_pair <= word_data;   // payload, lines up with prev_pair
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         quad_valid <= 1'b0;
         quad_sof   <= 1'b0;
      end
      else begin
         quad_valid <= accept & odd_line;
         quad_sof   <= accept & odd_line & first_quad;
      end
   end

endmodule: line_phase_tracker

// ==== design/raw_line_buffer.sv ====
// Raw line buffer
// holds one even Bayer line as CSI words, read back during the odd line
// through a registered port so it lands in block RAM

`timescale 1ns/100ps

`include "isp_config.svh"

module raw_line_buffer (
   input  logic                clk,
   input  logic                buf_wr,
   input  logic                buf_rd,
   input  isp_pkg::word_addr_t buf_addr,
   input  isp_pkg::word_t      buf_wdata,
   output isp_pkg::word_t      prev_pair
);
   import isp_pkg::*;

// ------------------------------
// storage
// ------------------------------
   // one entry per word, R/G pair of the even line
   word_t mem [`ISP_LINE_DEPTH];

   // write side, fed while the even line streams in
   always_ff @(posedge clk) begin
      if (buf_wr) begin
         mem[buf_addr] <= buf_wdata;
      end
   end

// ------------------------------
// read port
// ------------------------------
   // registered read, one cycle after buf_rd,
   // which matches the tracker's delayed cur_pair
   always_ff @(posedge clk) begin
      if (buf_rd) begin
         prev_pair <= mem[buf_addr];   // holds between reads
      end
   end

   // write and read never fire together: the tracker
   // uses one strobe per line depending on parity
   // entries past the even line's length keep old data

endmodule: raw_line_buffer

// ==== design/raw2rgb_combine.sv ====
// Raw to RGB combine
// turns one RGGB quad into a 24-bit pixel, greens averaged,
// registered together with its valid and start-of-frame strobes

`timescale 1ns/100ps

`include "isp_config.svh"

module raw2rgb_combine (
   input  logic           clk,
   input  logic           rst,
   input  isp_pkg::word_t prev_pair,   // even line, {G, R}
   input  isp_pkg::word_t cur_pair,    // odd line, {B, G}
   input  logic           quad_valid,
   input  logic           quad_sof,
   output isp_pkg::pix_t  rgb_pix,
   output logic           rgb_valid,
   output logic           rgb_sof
);
   import isp_pkg::*;

   raw_t                red, green_0, green_1, blue;
   logic [`ISP_RAW_W:0] green_sum;   // one extra bit for the carry
   raw_t                green;

// ------------------------------
// quad split and green average
// ------------------------------
   assign red       = prev_pair[`ISP_RAW_W-1:0];              // even line, even col
   assign green_0   = prev_pair[2*`ISP_RAW_W-1:`ISP_RAW_W];   // even line, odd col
   assign green_1   = cur_pair[`ISP_RAW_W-1:0];               // odd line, even col
   assign blue      = cur_pair[2*`ISP_RAW_W-1:`ISP_RAW_W];    // odd line, odd col

   assign green_sum = {1'b0, green_0} + {1'b0, green_1};
   assign green     = green_sum[`ISP_RAW_W:1];   // halve, fraction dropped

// ------------------------------
// output register
// ------------------------------
   always_ff @(posedge clk) begin
      if (quad_valid) begin
         rgb_pix <= {red, green, blue};   // held until the next quad
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         rgb_valid <= 1'b0;
         rgb_sof   <= 1'b0;
      end
      else begin
         rgb_valid <= quad_valid;
         rgb_sof   <= quad_valid & quad_sof;   // only with a real pixel
      end
   end

endmodule: raw2rgb_combine

// ==== design/isp_top.sv ====
// ISP raw-to-RGB top level
// unpacked CSI words in, half-resolution RGB pixels out,
// all in the byte clock domain

`timescale 1ns/100ps

module isp_top (
   input  logic           clk,          // CSI byte clock
   input  logic           rst,

   // from CSI receiver
   input  isp_pkg::word_t word_data,
   input  logic           word_valid,
   input  logic           in_line,
   input  logic           in_frame,

   // to clock-crossing FIFO
   output isp_pkg::pix_t  rgb_pix,
   output logic           rgb_valid,
   output logic           rgb_sof
);
   import isp_pkg::*;

// ------------------------------
// line framing
// ------------------------------
   logic       buf_wr, buf_rd;
   word_addr_t buf_addr;
   word_t      buf_wdata;
   word_t      cur_pair;
   logic       quad_valid, quad_sof;

   line_phase_tracker u_tracker (
      .clk        (clk),          //i
      .rst        (rst),          //i
      .word_data  (word_data),    //i'word_t
      .word_valid (word_valid),   //i
      .in_line    (in_line),      //i
      .in_frame   (in_frame),     //i
      .buf_wr     (buf_wr),       //o
      .buf_rd     (buf_rd),       //o
      .buf_addr   (buf_addr),     //o'word_addr_t
      .buf_wdata  (buf_wdata),    //o'word_t
      .cur_pair   (cur_pair),     //o'word_t
      .quad_valid (quad_valid),   //o
      .quad_sof   (quad_sof)      //o
   );

// ------------------------------
// even line storage
// ------------------------------
   word_t prev_pair;

   raw_line_buffer u_line_buf (
      .clk        (clk),          //i
      .buf_wr     (buf_wr),       //i
      .buf_rd     (buf_rd),       //i
      .buf_addr   (buf_addr),     //i'word_addr_t
      .buf_wdata  (buf_wdata),    //i'word_t
      .prev_pair  (prev_pair)     //o'word_t
   );

// ------------------------------
// quad to RGB
// ------------------------------
   raw2rgb_combine u_combine (
      .clk        (clk),          //i
      .rst        (rst),          //i
      .prev_pair  (prev_pair),    //i'word_t
      .cur_pair   (cur_pair),     //i'word_t
      .quad_valid (quad_valid),   //i
      .quad_sof   (quad_sof),     //i
      .rgb_pix    (rgb_pix),      //o'pix_t
      .rgb_valid  (rgb_valid),    //o
      .rgb_sof    (rgb_sof)       //o
   );

endmodule: isp_top

// ==== dv/isp_top_tb.sv ====
// ISP raw-to-RGB testbench
// CSI word stream from a data file, random idle gaps inside lines,
// expected RGB pixels popped from a queue on every output strobe

`timescale 1ns/100ps

module isp_top_tb;
   import isp_pkg::*;

   localparam int CLK_HALF      = 50;    // 100 ns byte clock
   localparam int RST_CYCLES    = 8;
   localparam int DRAIN_LIMIT   = 200;   // cycles allowed for the last pixels
   localparam int SETTLE_CYCLES = 4;     // watch for stray strobes after the end
   localparam int PIPE_LATENCY  = 2;     // odd word in, pixel out

   logic  clk = 1'b0;   // low from the start, no edge at time zero
   logic  rst;
   word_t word_data;
   logic  word_valid;
   logic  in_line;
   logic  in_frame;
   pix_t  rgb_pix;
   logic  rgb_valid;
   logic  rgb_sof;

// ------------------------------
// stimulus rows and expected pixels
// ------------------------------
   logic        stim_frame[$];
   logic        stim_line[$];
   logic        stim_valid[$];
   word_t       stim_word[$];
   logic [24:0] exp_q[$];   // {sof, r, g, b}

   int cycle;                  // posedges since time zero
   int last_word_cycle = -1;   // cycle of the last in-frame, in-line word
   int last_pix_cycle  = -1;
   int mismatch_cnt    = 0;
   int other_cnt       = 0;

   // DUT
   isp_top isp_top_inst (
      .clk        (clk),
      .rst        (rst),
      .word_data  (word_data),
      .word_valid (word_valid),
      .in_line    (in_line),
      .in_frame   (in_frame),
      .rgb_pix    (rgb_pix),
      .rgb_valid  (rgb_valid),
      .rgb_sof    (rgb_sof)
   );

   initial begin
      forever #CLK_HALF clk = ~clk;
   end

   always @(posedge clk) cycle <= cycle + 1;

// ------------------------------
// file reader
// ------------------------------
   task automatic load_stimulus();
      int          fd;
      int          n;
      int          lead;
      int          tag;
      int          f, l, v, s;
      logic [15:0] d;
      logic [23:0] pix;
      string       row;
      fd = $fopen("dv/isp_input.txt", "r");
      if (fd == 0) begin
         $display("cannot open the stimulus file dv/isp_input.txt");
         other_cnt++;
         return;
      end
      while (!$feof(fd)) begin
         row = "";
         n   = $fgets(row, fd);
         if (n > 0) begin
            tag = row.getc(0);
            if (tag == "S") begin   // one cycle of receiver signals
               n = $sscanf(row, "%c %d %d %d %h", lead, f, l, v, d);
               if (n == 5) begin
                  stim_frame.push_back(f[0]);
                  stim_line.push_back(l[0]);
                  stim_valid.push_back(v[0]);
                  stim_word.push_back(d);
               end
               else begin
                  $display("malformed word line in stimulus file: %s", row);
                  other_cnt++;
               end
            end
            else if (tag == "X") begin   // expected pixel, file order
               n = $sscanf(row, "%c %d %h", lead, s, pix);
               if (n == 3) exp_q.push_back({s[0], pix});
               else begin
                  $display("malformed pixel line in stimulus file: %s", row);
                  other_cnt++;
               end
            end
            else if (tag != "#" && tag != "\n" && tag != "\r") begin
               $display("unknown line in stimulus file: %s", row);
               other_cnt++;
            end
         end
      end
      $fclose(fd);
   endtask

// ------------------------------
// drivers, falling edge only
// ------------------------------
   task automatic drive_row(input logic f, input logic l, input logic v, input word_t d);
      @(negedge clk);
      in_frame   = f;
      in_line    = l;
      word_valid = v;
      word_data  = d;
      if (f && l && v) last_word_cycle = cycle;   // sampled at the next posedge
   endtask

   // levels held, strobe dropped
   task automatic idle_gap(input int n);
      repeat (n) begin
         @(negedge clk);
         word_valid = 1'b0;
      end
   endtask

// ------------------------------
// output monitor
// ------------------------------
   always @(negedge clk) begin
      logic [24:0] want;
      if (cycle <= RST_CYCLES) begin   // reset window
         assert (rgb_valid === 1'b0 && rgb_sof === 1'b0)
         else begin
            $display("output strobe high during reset at %0t", $time);
            other_cnt++;
         end
      end
      else if (rgb_valid === 1'b1) begin
         last_pix_cycle = cycle;
         if (exp_q.size() == 0) begin
            $display("rgb_valid at %0t with no pixel left to expect", $time);
            other_cnt++;
         end
         else begin
            want = exp_q.pop_front();
            assert (rgb_pix === want[23:0])
            else begin
               $display("FAILED at %0t: rgb_pix expected %06h actual %06h",
                        $time, want[23:0], rgb_pix);
               mismatch_cnt++;
            end
            assert (rgb_sof === want[24])
            else begin
               $display("FAILED at %0t: rgb_sof expected %0b actual %0b",
                        $time, want[24], rgb_sof);
               mismatch_cnt++;
            end
         end
      end
      else begin
         // sof never on its own
         assert (rgb_sof !== 1'b1)
         else begin
            $display("rgb_sof high without rgb_valid at %0t", $time);
            other_cnt++;
         end
      end
   end

// ------------------------------
// main sequence
// ------------------------------
   initial begin
      int gap;
      int wait_cnt;
      rst        = 1'b1;
      word_data  = '0;
      word_valid = 1'b0;
      in_line    = 1'b0;
      in_frame   = 1'b0;
      void'($urandom(32'h2a506c9d));
      load_stimulus();

      repeat (RST_CYCLES) @(negedge clk);
      rst = 1'b0;

      foreach (stim_word[i]) begin
         if (stim_valid[i]) begin
            gap = $urandom % 3;   // 0 to 2 idle cycles
            idle_gap(gap);
         end
         drive_row(stim_frame[i], stim_line[i], stim_valid[i], stim_word[i]);
      end
      @(negedge clk);
      word_valid = 1'b0;

      // wait for the remaining pixels
      wait_cnt = 0;
      while (exp_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
         @(posedge clk);
         wait_cnt++;
      end
      if (exp_q.size() != 0) begin
         $display("timeout: %0d expected pixels never appeared", exp_q.size());
         other_cnt++;
      end

      wait_cnt = 0;
      while (wait_cnt < SETTLE_CYCLES) begin   // late extras get caught here
         @(posedge clk);
         wait_cnt++;
      end

      // last odd word to last pixel
      assert (last_pix_cycle - last_word_cycle == PIPE_LATENCY)
      else begin
         $display("FAILED at %0t: rgb_valid latency expected %0d actual %0d",
                  $time, PIPE_LATENCY, last_pix_cycle - last_word_cycle);
         mismatch_cnt++;
      end

      $display("mismatches: %0d, other errors: %0d", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
         $display("TESTS PASSED");
      end
      else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule: isp_top_tb

// ==== isp_top.f ====
+incdir+include
design/isp_pkg.sv
design/line_phase_tracker.sv
design/raw_line_buffer.sv
design/raw2rgb_combine.sv
design/isp_top.sv
dv/isp_top_tb.sv

// ==== dv/isp_input.txt ====
# S in_frame in_line word_valid word_data   (hex word, even column in low byte)
# X sof rgb                                 (hex pixel, red top, blue low)
# two RGGB frames of four 4-word lines, pixels listed ahead of each odd line
#
# idle before the first frame
S 0 0 0 0000
S 0 0 0 0000
# ---- frame 1 ----
S 1 0 0 0000
S 1 0 0 0000
# line 0, even, in_line rises with the first word
S 1 1 1 2010
S 1 1 1 4130
S 1 1 1 ff50
S 1 1 1 8170
S 1 0 0 0000
# valid word between lines, ignored
S 1 0 1 dead
S 1 0 0 0000
# line 1, odd, in_line rises one cycle ahead of the words
X 1 102111
X 0 304222
X 0 50fe33
X 0 708044
S 1 1 0 0000
S 1 1 1 1122
S 1 1 1 2243
S 1 1 1 33fe
S 1 1 1 4480
S 1 0 0 0000
# line 2, even
S 1 1 1 0201
S 1 1 1 0403
S 1 1 1 0605
S 1 1 1 0807
S 1 0 0 0000
# line 3, odd
X 0 0105a0
X 0 0307b0
X 0 0509c0
X 0 070bd0
S 1 1 1 a009
S 1 1 1 b00b
S 1 1 1 c00d
S 1 1 1 d00f
S 1 0 0 0000
# empty trailing line, leaves the parity odd
S 1 1 0 0000
S 1 1 0 0000
S 1 0 0 0000
S 0 0 0 0000
# words outside any frame, ignored
S 0 1 1 beef
S 0 1 1 cafe
S 0 0 0 0000
S 0 0 0 0000
# ---- frame 2 ----
S 1 0 0 0000
S 1 0 0 0000
# line 0, even again after the frame start
S 1 1 1 80ff
S 1 1 1 7fee
S 1 1 1 01dd
S 1 1 1 00cc
S 1 0 0 0000
# line 1, odd
X 1 ff8011
X 0 ee8022
X 0 dd0133
X 0 cc0044
S 1 1 1 1180
S 1 1 1 2281
S 1 1 1 3302
S 1 1 1 4401
S 1 0 0 0000
# line 2, even
S 1 1 1 1234
S 1 1 1 5678
S 1 1 1 9abc
S 1 1 1 def0
S 1 0 0 0000
# line 3, odd
X 0 34100f
X 0 783a1f
X 0 bc642f
X 0 f08e3f
S 1 1 1 0f0e
S 1 1 1 1f1e
S 1 1 1 2f2e
S 1 1 1 3f3e
S 1 0 0 0000
# end of frame
S 0 0 0 0000
S 0 0 0 0000
